// ==== lsu_defines.svh ====
/*
 * Size parameters of the load/store unit
 *   Data memory depth and the derived index and window widths
 *   Queue depths and initial credit counts of every link
 */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Words in the local data memory
`define LSU_MEM_WORDS 256
`define LSU_MEM_IDX_W $clog2(`LSU_MEM_WORDS)
`define LSU_WIN_BYTES (`LSU_MEM_WORDS * 4)

// Address stage input queue, which sets the requester's initial credits
`define LSU_IN_CREDITS 4

// Input buffer of the access and writeback stages
`define LSU_STAGE_CREDITS 2

// Credits granted by the register-file consumer after reset
`define LSU_OUT_CREDITS 2

`endif

// ==== lsu_pkg.sv ====
/*
 * Shared types of the load/store unit
 *   op_t        operation code
 *   mem_word_u  memory word seen as bytes or halfwords
 *   is_load, is_store, access_size  operation classification
 */

`default_nettype none

package lsu_pkg;

    typedef enum logic [3:0] {
        NOP         = 4'd0,
        LOAD_BYTE   = 4'd1,
        LOAD_HALF   = 4'd2,
        LOAD_WORD   = 4'd3,
        LOAD_BYTE_U = 4'd4,
        LOAD_HALF_U = 4'd5,
        STORE_BYTE  = 4'd6,
        STORE_HALF  = 4'd7,
        STORE_WORD  = 4'd8
    } op_t;

    // Little endian, so element 0 holds the lowest byte address
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } mem_word_u;

    function automatic logic is_load(op_t op);
        return op inside {LOAD_BYTE, LOAD_HALF, LOAD_WORD, LOAD_BYTE_U, LOAD_HALF_U};
    endfunction

    function automatic logic is_store(op_t op);
        return op inside {STORE_BYTE, STORE_HALF, STORE_WORD};
    endfunction

    // A NOP counts as one byte so that it never faults on alignment
    function automatic logic [2:0] access_size(op_t op);
        case (op)
            LOAD_HALF, LOAD_HALF_U, STORE_HALF: return 3'd2;
            LOAD_WORD, STORE_WORD:              return 3'd4;
            default:                            return 3'd1;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== lsu_addr_stage.sv ====
/*
 * Address stage of the load/store unit
 *   Request queue filled under credit control
 *   Effective address inside the memory window and alignment fault
 *   Credit counter toward the access stage
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_addr_stage (
    input  logic         cache,
    input  logic         rstart,
    input  logic         in_valid,
    input  lsu_pkg::op_t op,
    input  logic [4:0]   rd,
    input  logic [31:0]  base,
    input  logic [31:0]  offset,
    input  logic [31:0]  wdata,
    output logic         in_credit,
    output logic         addr_valid,
    output lsu_pkg::op_t addr_op,
    output logic [4:0]   addr_rd,
    output logic [31:0]  addr_ea,
    output logic [31:0]  addr_wdata,
    output logic         addr_fault,
    input  logic         addr_credit
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_IN_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`LSU_STAGE_CREDITS + 1);

    op_t         q_op    [DEPTH];
    logic [4:0]  q_rd    [DEPTH];
    logic [31:0] q_ea    [DEPTH];
    logic [31:0] q_wdata [DEPTH];
    logic        q_fault [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] q_count;
    logic [CRD_W-1:0] credits;    // Free slots in the access stage buffer

    logic [31:0] ea;
    logic [2:0]  size;
    logic        misaligned;
    logic        pop;

    // ====================
    // Address computation
    // ====================

    always_comb begin
        ea         = (base + offset) & 32'(`LSU_WIN_BYTES - 1);   // Wrap inside the window
        size       = access_size(op);
        misaligned = |(ea[1:0] & 2'(size - 3'd1));
    end

    always_ff @(posedge cache) begin
        if (in_valid) begin
            q_op[wr_ptr]    <= op;
            q_rd[wr_ptr]    <= rd;
            q_ea[wr_ptr]    <= ea;
            q_wdata[wr_ptr] <= wdata;
            q_fault[wr_ptr] <= misaligned;
        end
    end

    // ====================
    // Queue and credits
    // ====================

    // The head leaves as soon as the access stage has room for it
    assign pop        = (q_count != '0) && (credits != '0);
    assign addr_valid = pop;
    assign in_credit  = pop;   // The freed slot goes straight back to the requester

    assign addr_op    = q_op[rd_ptr];
    assign addr_rd    = q_rd[rd_ptr];
    assign addr_ea    = q_ea[rd_ptr];
    assign addr_wdata = q_wdata[rd_ptr];
    assign addr_fault = q_fault[rd_ptr];

    always_ff @(posedge cache) begin
        if (rstart) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
            credits <= CRD_W'(`LSU_STAGE_CREDITS);
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_count <= q_count + CNT_W'(in_valid) - CNT_W'(pop);
            credits <= credits + CRD_W'(addr_credit) - CRD_W'(pop);
        end
    end

endmodule

`default_nettype wire

// ==== lsu_access_stage.sv ====
/*
 * Access stage of the load/store unit
 *   Two-entry input buffer and credit counter toward writeback
 *   Store lane placement with byte strobes
 *   Memory access and load alignment with sign or zero extension
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_access_stage (
    input  logic                      cache,
    input  logic                      rstart,
    input  logic                      addr_valid,
    input  lsu_pkg::op_t              addr_op,
    input  logic [4:0]                addr_rd,
    input  logic [31:0]               addr_ea,
    input  logic [31:0]               addr_wdata,
    input  logic                      addr_fault,
    output logic                      addr_credit,
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [3:0]                mem_strb,
    output logic [`LSU_MEM_IDX_W-1:0] mem_index,
    output logic [31:0]               mem_wdata,
    input  logic [31:0]               mem_rdata,
    output logic                      acc_valid,
    output lsu_pkg::op_t              acc_op,
    output logic [4:0]                acc_rd,
    output logic [31:0]               acc_result,
    output logic                      acc_fault,
    input  logic                      acc_credit
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_STAGE_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`LSU_STAGE_CREDITS + 1);

    op_t         b_op    [DEPTH];
    logic [4:0]  b_rd    [DEPTH];
    logic [31:0] b_ea    [DEPTH];
    logic [31:0] b_wdata [DEPTH];
    logic        b_fault [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] b_count;
    logic [CRD_W-1:0] credits;

    op_t         h_op;
    logic [31:0] h_ea;
    logic        h_load;          // Load that really reads memory
    logic        h_store;         // Store that really writes memory
    logic        take;

    logic        p1_valid;        // A load waits one cycle for mem_rdata
    op_t         p1_op;
    logic [4:0]  p1_rd;
    logic [1:0]  p1_lane;

    mem_word_u   rword;
    logic [31:0] load_result;

    always_ff @(posedge cache) begin
        if (addr_valid) begin
            b_op[wr_ptr]    <= addr_op;
            b_rd[wr_ptr]    <= addr_rd;
            b_ea[wr_ptr]    <= addr_ea;
            b_wdata[wr_ptr] <= addr_wdata;
            b_fault[wr_ptr] <= addr_fault;
        end
    end

    assign h_op    = b_op[rd_ptr];
    assign h_ea    = b_ea[rd_ptr];
    assign h_load  = is_load(h_op) && !b_fault[rd_ptr];
    assign h_store = is_store(h_op) && !b_fault[rd_ptr];

    // A one-cycle result right behind a load would land with it, so it waits a cycle
    assign take        = (b_count != '0) && (credits != '0) && !(p1_valid && !h_load);
    assign addr_credit = take;

    // ====================
    // Memory port
    // ====================

    assign mem_en    = take && (h_load || h_store);
    assign mem_we    = take && h_store;
    assign mem_index = h_ea[`LSU_MEM_IDX_W+1:2];

    always_comb begin
        mem_wdata = b_wdata[rd_ptr];
        mem_strb  = 4'b0000;
        case (h_op)
            STORE_BYTE: begin
                mem_wdata = b_wdata[rd_ptr] << {h_ea[1:0], 3'b000};
                mem_strb  = 4'b0001 << h_ea[1:0];
            end
            STORE_HALF: begin
                mem_wdata = b_wdata[rd_ptr] << {h_ea[1], 4'b0000};
                mem_strb  = h_ea[1] ? 4'b1100 : 4'b0011;
            end
            STORE_WORD: mem_strb = 4'b1111;
            default: ;
        endcase
    end

    // Pick the addressed lane and extend it to a full register
    always_comb begin
        rword = mem_rdata;
        case (p1_op)
            LOAD_BYTE:   load_result = {{24{rword.b[p1_lane][7]}}, rword.b[p1_lane]};
            LOAD_BYTE_U: load_result = {24'h000000, rword.b[p1_lane]};
            LOAD_HALF:   load_result = {{16{rword.h[p1_lane[1]][15]}}, rword.h[p1_lane[1]]};
            LOAD_HALF_U: load_result = {16'h0000, rword.h[p1_lane[1]]};
            default:     load_result = rword;
        endcase
    end

    // ====================
    // Results
    // ====================

    always_ff @(posedge cache) begin
        if (take && h_load) begin
            p1_op   <= h_op;
            p1_rd   <= b_rd[rd_ptr];
            p1_lane <= h_ea[1:0];
        end
        if (p1_valid) begin
            acc_op     <= p1_op;
            acc_rd     <= p1_rd;
            acc_result <= load_result;
            acc_fault  <= 1'b0;
        end else if (take) begin
            acc_op     <= h_op;
            acc_rd     <= b_rd[rd_ptr];
            acc_result <= h_store ? h_ea : 32'h0;   // Faults and NOPs return zero
            acc_fault  <= b_fault[rd_ptr];
        end
    end

    always_ff @(posedge cache) begin
        if (rstart) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            b_count   <= '0;
            credits   <= CRD_W'(`LSU_STAGE_CREDITS);
            p1_valid  <= 1'b0;
            acc_valid <= 1'b0;
        end else begin
            if (addr_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            b_count   <= b_count + CNT_W'(addr_valid) - CNT_W'(take);
            credits   <= credits + CRD_W'(acc_credit) - CRD_W'(take);  // Slot reserved at take
            p1_valid  <= take && h_load;
            acc_valid <= (take && !h_load) || p1_valid;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_data_ram.sv ====
/*
 * Local data memory of the load/store unit
 *   Byte-strobed write, registered read one cycle after mem_en
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_data_ram (
    input  logic                      cache,
    input  logic                      mem_en,
    input  logic                      mem_we,
    input  logic [3:0]                mem_strb,
    input  logic [`LSU_MEM_IDX_W-1:0] mem_index,
    input  logic [31:0]               mem_wdata,
    output logic [31:0]               mem_rdata
);

    logic [31:0] mem [`LSU_MEM_WORDS] = '{default: 32'h0};   // Starts cleared

    always_ff @(posedge cache) begin
        if (mem_en) begin
            if (mem_we) begin
                // Only the strobed lanes change
                for (int i = 0; i < 4; i++) begin
                    if (mem_strb[i]) begin
                        mem[mem_index][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                    end
                end
            end else begin
                mem_rdata <= mem[mem_index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== lsu_writeback_stage.sv ====
/*
 * Writeback stage of the load/store unit
 *   Result queue fed by the access stage
 *   Credit counter toward the register-file consumer
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_writeback_stage (
    input  logic         cache,
    input  logic         rstart,
    input  logic         acc_valid,
    input  lsu_pkg::op_t acc_op,
    input  logic [4:0]   acc_rd,
    input  logic [31:0]  acc_result,
    input  logic         acc_fault,
    output logic         acc_credit,
    output logic         out_valid,
    output lsu_pkg::op_t out_op,
    output logic [4:0]   out_rd,
    output logic [31:0]  out_result,
    output logic         out_fault,
    input  logic         out_credit
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_STAGE_CREDITS;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(`LSU_OUT_CREDITS + 1);

    op_t         r_op     [DEPTH];
    logic [4:0]  r_rd     [DEPTH];
    logic [31:0] r_result [DEPTH];
    logic        r_fault  [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] r_count;
    logic [CRD_W-1:0] credits;     // Free slots at the consumer

    always_ff @(posedge cache) begin
        if (acc_valid) begin
            r_op[wr_ptr]     <= acc_op;
            r_rd[wr_ptr]     <= acc_rd;
            r_result[wr_ptr] <= acc_result;
            r_fault[wr_ptr]  <= acc_fault;
        end
    end

    // Send the head whenever the consumer has room
    assign out_valid  = (r_count != '0) && (credits != '0);
    assign acc_credit = out_valid;
    assign out_op     = r_op[rd_ptr];
    assign out_rd     = r_rd[rd_ptr];
    assign out_result = r_result[rd_ptr];
    assign out_fault  = r_fault[rd_ptr];

    always_ff @(posedge cache) begin
        if (rstart) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            r_count <= '0;
            credits <= CRD_W'(`LSU_OUT_CREDITS);
        end else begin
            if (acc_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (out_valid) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            r_count <= r_count + CNT_W'(acc_valid) - CNT_W'(out_valid);
            credits <= credits + CRD_W'(out_credit) - CRD_W'(out_valid);
        end
    end

endmodule

`default_nettype wire

// ==== lsu_top.sv ====
/*
 * Top level of the load/store unit
 *   Address, access and writeback stages around the data memory
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_top (
    input  logic         cache,
    input  logic         rstart,
    input  logic         in_valid,
    input  lsu_pkg::op_t op,
    input  logic [4:0]   rd,
    input  logic [31:0]  base,
    input  logic [31:0]  offset,
    input  logic [31:0]  wdata,
    output logic         in_credit,
    output logic         out_valid,
    output lsu_pkg::op_t out_op,
    output logic [4:0]   out_rd,
    output logic [31:0]  out_result,
    output logic         out_fault,
    input  logic         out_credit
);
    import lsu_pkg::*;

    // Address stage to access stage
    logic        addr_valid;
    op_t         addr_op;
    logic [4:0]  addr_rd;
    logic [31:0] addr_ea;
    logic [31:0] addr_wdata;
    logic        addr_fault;
    logic        addr_credit;

    // Access stage to writeback stage
    logic        acc_valid;
    op_t         acc_op;
    logic [4:0]  acc_rd;
    logic [31:0] acc_result;
    logic        acc_fault;
    logic        acc_credit;

    logic                      mem_en;
    logic                      mem_we;
    logic [3:0]                mem_strb;
    logic [`LSU_MEM_IDX_W-1:0] mem_index;
    logic [31:0]               mem_wdata;
    logic [31:0]               mem_rdata;

    lsu_addr_stage i_addr_stage (
        .cache, .rstart, .in_valid, .op, .rd, .base, .offset, .wdata, .in_credit,
        .addr_valid, .addr_op, .addr_rd, .addr_ea, .addr_wdata, .addr_fault, .addr_credit
    );

    lsu_access_stage i_access_stage (
        .cache, .rstart,
        .addr_valid, .addr_op, .addr_rd, .addr_ea, .addr_wdata, .addr_fault, .addr_credit,
        .mem_en, .mem_we, .mem_strb, .mem_index, .mem_wdata, .mem_rdata,
        .acc_valid, .acc_op, .acc_rd, .acc_result, .acc_fault, .acc_credit
    );

    lsu_data_ram i_data_ram (
        .cache, .mem_en, .mem_we, .mem_strb, .mem_index, .mem_wdata, .mem_rdata
    );

    lsu_writeback_stage i_writeback_stage (
        .cache, .rstart,
        .acc_valid, .acc_op, .acc_rd, .acc_result, .acc_fault, .acc_credit,
        .out_valid, .out_op, .out_rd, .out_result, .out_fault, .out_credit
    );

endmodule

`default_nettype wire

// ==== lsu_checker.sv ====
/*
 * Assertions on the outer ports of the load/store unit
 *   Consumer credit limit on out_valid
 *   Quiet credit and valid outputs during reset
 *   Request credits never exceed accepted requests
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_checker (
    input logic cache,
    input logic rstart,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit
);
    timeunit 1ns;
    timeprecision 100ps;

    int cons_credits;   // Free slots at the consumer as the top level sees them
    int outstanding;    // Requests accepted whose slot has not come back

    always_ff @(posedge cache) begin
        if (rstart) begin
            cons_credits <= `LSU_OUT_CREDITS;
            outstanding  <= 0;
        end else begin
            cons_credits <= cons_credits + int'(out_credit) - int'(out_valid);
            outstanding  <= outstanding + int'(in_valid) - int'(in_credit);
        end
    end

    a_out_credit: assert property (@(posedge cache) disable iff (rstart)
        out_valid |-> cons_credits > 0)
        else $error("out_valid raised with no consumer credit left");

    a_reset_quiet: assert property (@(posedge cache)
        (rstart && $past(rstart)) |-> (!in_credit && !out_valid))
        else $error("in_credit or out_valid high during reset");

    a_in_credit: assert property (@(posedge cache) disable iff (rstart)
        in_credit |-> outstanding > 0)
        else $error("in_credit returned with no request accepted");

endmodule

`default_nettype wire

// ==== lsu_tb.sv ====
/*
 * Testbench of the load/store unit
 *   Clock, reset and requests read from lsu_input.txt
 *   Credit-limited request driver and random consumer credit return
 *   In-order checking of every result against the expected values of its line
 */

`default_nettype none
`include "lsu_defines.svh"

module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_pkg::*;

    localparam int CREDIT_TIMEOUT = 200;    // Cycles a request may wait for a credit
    localparam int RESULT_TIMEOUT = 1000;   // Cycles allowed for the last results to drain
    localparam int IDLE_CYCLES    = 8;

    logic        cache;
    logic        rstart;
    logic        in_valid;
    op_t         op;
    logic [4:0]  rd;
    logic [31:0] base;
    logic [31:0] offset;
    logic [31:0] wdata;
    logic        in_credit;
    logic        out_valid;
    op_t         out_op;
    logic [4:0]  out_rd;
    logic [31:0] out_result;
    logic        out_fault;
    logic        out_credit;

    // Requests as read from the file, one entry per line
    logic [31:0] v_op[$];
    logic [31:0] v_rd[$];
    logic [31:0] v_base[$];
    logic [31:0] v_offset[$];
    logic [31:0] v_wdata[$];
    logic [31:0] v_result[$];
    logic [31:0] v_fault[$];

    // Expected results in request order
    logic [31:0] exp_op[$];
    logic [31:0] exp_rd[$];
    logic [31:0] exp_result[$];
    logic [31:0] exp_fault[$];

    int sent     = 0;
    int returned = 0;   // in_credit pulses seen
    int received = 0;
    int given    = 0;   // out_credit pulses returned by the consumer
    int cycle    = 0;
    int last_due = 0;
    int due_q[$];       // Cycles in which the consumer returns a credit

    lsu_top i_lsu_top (.*);

    bind lsu_top lsu_checker i_checker (
        .cache(cache), .rstart(rstart), .in_valid(in_valid), .in_credit(in_credit),
        .out_valid(out_valid), .out_credit(out_credit)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("mismatch %s got 0x%08h expected 0x%08h", name, got, expected));
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_rd;
        logic [31:0] f_base;
        logic [31:0] f_offset;
        logic [31:0] f_wdata;
        logic [31:0] f_result;
        logic [31:0] f_fault;
        fd = $fopen("lsu_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open lsu_input.txt for reading");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;    // Blank line or column description
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_op, f_rd, f_base, f_offset, f_wdata, f_result, f_fault);
            if (n != 7) begin
                abort_run({"malformed line in lsu_input.txt ", line});
            end
            v_op.push_back(f_op);
            v_rd.push_back(f_rd);
            v_base.push_back(f_base);
            v_offset.push_back(f_offset);
            v_wdata.push_back(f_wdata);
            v_result.push_back(f_result);
            v_fault.push_back(f_fault);
        end
        $fclose(fd);
        if (v_op.size() == 0) begin
            abort_run("lsu_input.txt holds no requests");
        end
    endtask

    // ====================
    // Clock and consumer
    // ====================

    initial begin
        cache = 1'b0;
        forever #10 cache = ~cache;
    end

    // A credit goes back in its scheduled cycle, at most one per cycle
    initial begin
        out_credit <= 1'b0;
        forever begin
            @(posedge cache);
            cycle = cycle + 1;
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                due_q.delete(0);
                out_credit <= 1'b1;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // ====================
    // Result monitor
    // ====================

    // Outputs are sampled on the falling edge, where they are stable
    initial begin
        int delay;
        int due;
        void'($urandom(32'h4347));
        forever begin
            @(negedge cache);
            if (!rstart) begin
                if (in_credit) returned++;
                if (out_valid) begin
                    if (received - given >= `LSU_OUT_CREDITS) begin
                        abort_run("a result was sent while the consumer had no free slot");
                    end
                    if (exp_result.size() == 0) begin
                        abort_run("a result arrived with no request outstanding");
                    end
                    check_value("out_op", 32'(out_op), exp_op.pop_front());
                    check_value("out_rd", 32'(out_rd), exp_rd.pop_front());
                    check_value("out_result", out_result, exp_result.pop_front());
                    check_value("out_fault", 32'(out_fault), exp_fault.pop_front());
                    received++;
                    delay = int'($urandom_range(3, 0));
                    due   = cycle + 1 + delay;
                    if (due <= last_due) due = last_due + 1;
                    last_due = due;
                    due_q.push_back(due);
                end
                if (out_credit) given++;
            end
        end
    end

    // ====================
    // Request driver
    // ====================

    initial begin
        int wait_cycles;
        rstart   <= 1'b1;
        in_valid <= 1'b0;
        op       <= NOP;
        rd       <= 5'd0;
        base     <= 32'h0;
        offset   <= 32'h0;
        wdata    <= 32'h0;
        load_vectors();
        repeat (3) @(posedge cache);
        rstart <= 1'b0;
        @(posedge cache);
        for (int i = 0; i < v_op.size(); i++) begin
            wait_cycles = 0;
            while (sent - returned >= `LSU_IN_CREDITS) begin
                in_valid <= 1'b0;
                @(posedge cache);
                wait_cycles++;
                if (wait_cycles > CREDIT_TIMEOUT) begin
                    abort_run("timeout while waiting for a request credit");
                end
            end
            in_valid <= 1'b1;
            op       <= op_t'(v_op[i][3:0]);
            rd       <= v_rd[i][4:0];
            base     <= v_base[i];
            offset   <= v_offset[i];
            wdata    <= v_wdata[i];
            exp_op.push_back(v_op[i]);
            exp_rd.push_back(v_rd[i]);
            exp_result.push_back(v_result[i]);
            exp_fault.push_back(v_fault[i]);
            sent++;
            @(posedge cache);
        end
        in_valid <= 1'b0;
        wait_cycles = 0;
        while (received < sent) begin
            @(posedge cache);
            wait_cycles++;
            if (wait_cycles > RESULT_TIMEOUT) begin
                abort_run("timeout while waiting for the last results");
            end
        end
        repeat (IDLE_CYCLES) @(posedge cache);   // A repeated result would show up here
        if (exp_result.size() == 0 && received == sent) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("results are missing at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== lsu_input.txt ====
# Columns in hex are op rd base offset wdata expected_result expected_fault
# Op codes 0 NOP 1 LB 2 LH 3 LW 4 LBU 5 LHU 6 SB 7 SH 8 SW
8 01 00000100 00000000 11223344 00000100 0
3 02 00000100 00000000 00000000 11223344 0
6 03 00000100 00000001 000000aa 00000101 0
7 04 000000fe 00000004 0000beef 00000102 0
3 05 00000100 00000000 00000000 beefaa44 0
8 06 00000104 00000000 80ff7f01 00000104 0
1 07 00000104 00000000 00000000 00000001 0
1 08 00000104 00000001 00000000 0000007f 0
1 09 00000104 00000002 00000000 ffffffff 0
1 0a 00000104 00000003 00000000 ffffff80 0
4 0b 00000104 00000002 00000000 000000ff 0
4 0c 00000104 00000003 00000000 00000080 0
2 0d 00000104 00000000 00000000 00007f01 0
2 0e 00000104 00000002 00000000 ffff80ff 0
5 0f 00000104 00000002 00000000 000080ff 0
8 10 00000104 00000002 deadbeef 00000000 1
7 11 00000105 00000000 00001234 00000000 1
3 12 00000104 00000000 00000000 80ff7f01 0
3 13 00000101 00000000 00000000 00000000 1
2 14 00000103 00000000 00000000 00000000 1
8 15 000003fc 00000008 cafef00d 00000004 0
3 16 00000000 00000004 00000000 cafef00d 0
8 17 00001000 00000010 0badc0de 00000010 0
3 18 00000010 00000000 00000000 0badc0de 0
6 19 00000020 fffffffc 0000005a 0000001c 0
4 1a 0000001c 00000000 00000000 0000005a 0
0 00 00000003 00000000 00000000 00000000 0
7 1b 00000100 00000000 ffff1234 00000100 0
6 1c 00000100 00000003 00000077 00000103 0
3 1d 00000100 00000000 00000000 77ef1234 0
2 1e 00000100 00000002 00000000 000077ef 0
1 1f 00000102 00000000 00000000 ffffffef 0

// ==== lsu.f ====
+incdir+.
lsu_pkg.sv
lsu_addr_stage.sv
lsu_access_stage.sv
lsu_data_ram.sv
lsu_writeback_stage.sv
lsu_top.sv
lsu_checker.sv
lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the load/store unit testbench with Verilator, runs it and searches the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
rm -rf obj_dir

verilator --binary --timing --assert --top-module lsu_tb -f lsu.f -o lsu_sim \
    && ./obj_dir/lsu_sim 2>&1 | tee sim.log \
    || echo "Build or simulation did not complete"

grep -q "Verification passed" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
